// File: flist.f
+incdir+src
src/btac_pkg.sv
src/btb_ram.sv
src/btac_lookup.sv
src/btac_update.sv
src/btac_resolve.sv
src/btac_ctrl.sv
src/btac.sv
testbench/btac_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the BTAC testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f flist.f --top-module btac_tb -o btac_sim \
  || { echo "Verilator build failed"; exit 1; }

out="$(./obj_dir/btac_sim)"
echo "$out"
echo "$out" | grep -q "TESTBENCH PASSED" && exit 0 || exit 1

// File: src/btac.sv
`timescale 1ns/10ps

module btac
  import btac_pkg::*;
(
  input  logic  clock,
  input  logic  reset,
  input  addr_t get_pc0_i,
  input  addr_t get_pc1_i,
  input  logic  clear_i,
  input  logic  stall_i,
  input  addr_t upd_pc0_i,
  input  addr_t upd_pc1_i,
  input  addr_t upd_npc0_i,
  input  addr_t upd_npc1_i,
  input  addr_t upd_addr0_i,
  input  addr_t upd_addr1_i,
  input  logic  upd_jal0_i,
  input  logic  upd_jal1_i,
  input  logic  upd_branch0_i,
  input  logic  upd_branch1_i,
  input  logic  upd_jump0_i,
  input  logic  upd_jump1_i,
  input  logic  upd_taken0_i,
  input  logic  upd_taken1_i,
  input  addr_t upd_taddr0_i,
  input  addr_t upd_taddr1_i,
  input  sat_t  upd_tsat0_i,
  input  sat_t  upd_tsat1_i,
  output logic  pred_taken0_o,
  output logic  pred_taken1_o,
  output addr_t pred_taddr0_o,
  output addr_t pred_taddr1_o,
  output sat_t  pred_tsat0_o,
  output sat_t  pred_tsat1_o,
  output logic  pred_hazard0_o,
  output logic  pred_hazard1_o,
  output logic  pred_miss_o,
  output addr_t pred_maddr_o
);

  btb_index_t raddr0;
  btb_index_t raddr1;
  btb_index_t waddr;
  btb_index_t upd_waddr;
  btb_entry_t rdata0;
  btb_entry_t rdata1;
  btb_entry_t wdata;
  btb_entry_t upd_wdata;
  logic       wen;
  logic       upd_wen;
  addr_t      pc0;
  addr_t      pc1;
  logic       hit_taken0;
  logic       hit_taken1;
  addr_t      taddr0;
  addr_t      taddr1;
  sat_t       tsat0;
  sat_t       tsat1;
  logic       miss0;
  logic       miss1;
  addr_t      maddr0;
  addr_t      maddr1;

  btac_ctrl u_ctrl (
    .clock          (clock),
    .reset          (reset),
    .get_pc0_i      (get_pc0_i),
    .get_pc1_i      (get_pc1_i),
    .clear_i        (clear_i),
    .stall_i        (stall_i),
    .hit_taken0_i   (hit_taken0),
    .hit_taken1_i   (hit_taken1),
    .taddr0_i       (taddr0),
    .taddr1_i       (taddr1),
    .tsat0_i        (tsat0),
    .tsat1_i        (tsat1),
    .upd_wen_i      (upd_wen),
    .upd_waddr_i    (upd_waddr),
    .upd_wdata_i    (upd_wdata),
    .miss0_i        (miss0),
    .miss1_i        (miss1),
    .maddr0_i       (maddr0),
    .maddr1_i       (maddr1),
    .raddr0_o       (raddr0),
    .raddr1_o       (raddr1),
    .wen_o          (wen),
    .waddr_o        (waddr),
    .wdata_o        (wdata),
    .pc0_o          (pc0),
    .pc1_o          (pc1),
    .pred_taken0_o  (pred_taken0_o),
    .pred_taken1_o  (pred_taken1_o),
    .pred_taddr0_o  (pred_taddr0_o),
    .pred_taddr1_o  (pred_taddr1_o),
    .pred_tsat0_o   (pred_tsat0_o),
    .pred_tsat1_o   (pred_tsat1_o),
    .pred_hazard0_o (pred_hazard0_o),
    .pred_hazard1_o (pred_hazard1_o),
    .pred_miss_o    (pred_miss_o),
    .pred_maddr_o   (pred_maddr_o)
  );

  btb_ram u_ram (
    .clock    (clock),
    .raddr0_i (raddr0),
    .raddr1_i (raddr1),
    .waddr_i  (waddr),
    .wen_i    (wen),
    .wdata_i  (wdata),
    .rdata0_o (rdata0),
    .rdata1_o (rdata1)
  );

  btac_lookup u_lookup (
    .rdata0_i     (rdata0),
    .rdata1_i     (rdata1),
    .pc0_i        (pc0),
    .pc1_i        (pc1),
    .hit_taken0_o (hit_taken0),
    .hit_taken1_o (hit_taken1),
    .taddr0_o     (taddr0),
    .taddr1_o     (taddr1),
    .tsat0_o      (tsat0),
    .tsat1_o      (tsat1)
  );

  btac_update u_update (
    .upd_pc0_i     (upd_pc0_i),
    .upd_pc1_i     (upd_pc1_i),
    .upd_addr0_i   (upd_addr0_i),
    .upd_addr1_i   (upd_addr1_i),
    .upd_tsat0_i   (upd_tsat0_i),
    .upd_tsat1_i   (upd_tsat1_i),
    .upd_jal0_i    (upd_jal0_i),
    .upd_jal1_i    (upd_jal1_i),
    .upd_branch0_i (upd_branch0_i),
    .upd_branch1_i (upd_branch1_i),
    .upd_jump0_i   (upd_jump0_i),
    .upd_jump1_i   (upd_jump1_i),
    .wen_o         (upd_wen),
    .waddr_o       (upd_waddr),
    .wdata_o       (upd_wdata)
  );

  btac_resolve u_resolve (
    .upd_taken0_i  (upd_taken0_i),
    .upd_taken1_i  (upd_taken1_i),
    .upd_taddr0_i  (upd_taddr0_i),
    .upd_taddr1_i  (upd_taddr1_i),
    .upd_jump0_i   (upd_jump0_i),
    .upd_jump1_i   (upd_jump1_i),
    .upd_branch0_i (upd_branch0_i),
    .upd_branch1_i (upd_branch1_i),
    .upd_addr0_i   (upd_addr0_i),
    .upd_addr1_i   (upd_addr1_i),
    .upd_npc0_i    (upd_npc0_i),
    .upd_npc1_i    (upd_npc1_i),
    .miss0_o       (miss0),
    .miss1_o       (miss1),
    .maddr0_o      (maddr0),
    .maddr1_o      (maddr1)
  );

endmodule

// File: src/btac_ctrl.sv
`timescale 1ns/10ps

module btac_ctrl
  import btac_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  addr_t      get_pc0_i,
  input  addr_t      get_pc1_i,
  input  logic       clear_i,
  input  logic       stall_i,
  input  logic       hit_taken0_i,
  input  logic       hit_taken1_i,
  input  addr_t      taddr0_i,
  input  addr_t      taddr1_i,
  input  sat_t       tsat0_i,
  input  sat_t       tsat1_i,
  input  logic       upd_wen_i,
  input  btb_index_t upd_waddr_i,
  input  btb_entry_t upd_wdata_i,
  input  logic       miss0_i,
  input  logic       miss1_i,
  input  addr_t      maddr0_i,
  input  addr_t      maddr1_i,
  output btb_index_t raddr0_o,
  output btb_index_t raddr1_o,
  output logic       wen_o,
  output btb_index_t waddr_o,
  output btb_entry_t wdata_o,
  output addr_t      pc0_o,
  output addr_t      pc1_o,
  output logic       pred_taken0_o,
  output logic       pred_taken1_o,
  output addr_t      pred_taddr0_o,
  output addr_t      pred_taddr1_o,
  output sat_t       pred_tsat0_o,
  output sat_t       pred_tsat1_o,
  output logic       pred_hazard0_o,
  output logic       pred_hazard1_o,
  output logic       pred_miss_o,
  output addr_t      pred_maddr_o
);

  localparam int IW = $bits(btb_index_t);

  addr_t pc0_q;
  addr_t pc1_q;
  addr_t pc0_next;
  addr_t pc1_next;
  addr_t maddr0_q;
  addr_t maddr1_q;
  logic  miss0_q;
  logic  miss1_q;
  logic  blank;

  // During clear the old lookup is kept, so the RAM index does not move
  assign pc0_next = clear_i ? pc0_q : get_pc0_i;
  assign pc1_next = clear_i ? pc1_q : get_pc1_i;
  assign raddr0_o = pc0_next[IW+1:2];
  assign raddr1_o = pc1_next[IW+1:2];
  assign pc0_o = pc0_q;
  assign pc1_o = pc1_q;

  assign wen_o = upd_wen_i & ~clear_i;
  assign waddr_o = upd_waddr_i;
  assign wdata_o = upd_wdata_i;

  assign blank = stall_i | clear_i;
  assign pred_taken0_o = hit_taken0_i & ~blank;
  assign pred_taken1_o = hit_taken1_i & ~blank;
  assign pred_taddr0_o = blank ? '0 : taddr0_i;
  assign pred_taddr1_o = blank ? '0 : taddr1_i;
  assign pred_tsat0_o = blank ? '0 : tsat0_i;
  assign pred_tsat1_o = blank ? '0 : tsat1_i;

  assign pred_hazard0_o = miss0_i & ~clear_i;
  assign pred_hazard1_o = miss1_i & ~clear_i;

  always_ff @(posedge clock) begin
    if (!reset) begin
      pc0_q <= '0;
      pc1_q <= '0;
      miss0_q <= 1'b0;
      miss1_q <= 1'b0;
      maddr0_q <= '0;
      maddr1_q <= '0;
    end else begin
      pc0_q <= pc0_next;
      pc1_q <= pc1_next;
      miss0_q <= pred_hazard0_o;
      miss1_q <= pred_hazard1_o;
      maddr0_q <= clear_i ? '0 : maddr0_i;
      maddr1_q <= clear_i ? '0 : maddr1_i;
    end
  end

  // Slot 0 redirect takes precedence
  assign pred_miss_o = miss0_q | miss1_q;
  assign pred_maddr_o = miss0_q ? maddr0_q : maddr1_q;

  // A cleared cycle must never produce a redirect on the next one
  a_no_miss_after_clear: assert property (
    @(posedge clock) disable iff (!reset) clear_i |=> !pred_miss_o
  );

endmodule

// File: src/btac_defines.svh
`ifndef BTAC_DEFINES_SVH
`define BTAC_DEFINES_SVH

// Index bits pick the buffer entry from the PC bits just above the word offset
`define BTAC_INDEX_BITS 4

// Direct-mapped buffer, one entry per index value
`define BTAC_DEPTH (1 << `BTAC_INDEX_BITS)

`endif

// File: src/btac_lookup.sv
`timescale 1ns/10ps

module btac_lookup
  import btac_pkg::*;
(
  input  btb_entry_t rdata0_i,
  input  btb_entry_t rdata1_i,
  input  addr_t      pc0_i,
  input  addr_t      pc1_i,
  output logic       hit_taken0_o,
  output logic       hit_taken1_o,
  output addr_t      taddr0_o,
  output addr_t      taddr1_o,
  output sat_t       tsat0_o,
  output sat_t       tsat1_o
);

  localparam int EW = $bits(btb_entry_t);
  localparam int TW = $bits(btb_tag_t);

  btb_tag_t tag0;
  btb_tag_t tag1;
  btb_tag_t pc_tag0;
  btb_tag_t pc_tag1;
  sat_t     sat0;
  sat_t     sat1;

  // Entry layout is tag, target, counter from the top down
  assign tag0 = rdata0_i[EW-1 -: TW];
  assign tag1 = rdata1_i[EW-1 -: TW];

  assign taddr0_o = rdata0_i[33:2];
  assign taddr1_o = rdata1_i[33:2];

  assign sat0 = rdata0_i[1:0];
  assign sat1 = rdata1_i[1:0];

  assign tsat0_o = sat0;
  assign tsat1_o = sat1;

  assign pc_tag0 = pc0_i[31 -: TW];
  assign pc_tag1 = pc1_i[31 -: TW];

  // A hit only counts as taken when the counter sits in its upper half
  assign hit_taken0_o = sat0[1] && (tag0 == pc_tag0);
  assign hit_taken1_o = sat1[1] && (tag1 == pc_tag1);

endmodule

// File: src/btac_pkg.sv
`include "btac_defines.svh"

package btac_pkg;

  // Instruction address
  typedef logic [31:0] addr_t;

  // PC bits from 2 upward
  typedef logic [`BTAC_INDEX_BITS-1:0] btb_index_t;

  // PC bits above the index
  typedef logic [29-`BTAC_INDEX_BITS:0] btb_tag_t;

  // Saturating counter, upper bit means predict taken
  typedef logic [1:0] sat_t;

  // Tag in the upper bits, then the 32-bit target, then the counter in bits 1:0
  typedef logic [63-`BTAC_INDEX_BITS:0] btb_entry_t;

endpackage

// File: src/btac_resolve.sv
`timescale 1ns/10ps

module btac_resolve
  import btac_pkg::*;
(
  input  logic  upd_taken0_i,
  input  logic  upd_taken1_i,
  input  addr_t upd_taddr0_i,
  input  addr_t upd_taddr1_i,
  input  logic  upd_jump0_i,
  input  logic  upd_jump1_i,
  input  logic  upd_branch0_i,
  input  logic  upd_branch1_i,
  input  addr_t upd_addr0_i,
  input  addr_t upd_addr1_i,
  input  addr_t upd_npc0_i,
  input  addr_t upd_npc1_i,
  output logic  miss0_o,
  output logic  miss1_o,
  output addr_t maddr0_o,
  output addr_t maddr1_o
);

  function automatic void resolve_slot(
    input  logic  taken,
    input  addr_t taddr,
    input  logic  jump,
    input  logic  branch,
    input  addr_t addr,
    input  addr_t npc,
    output logic  miss,
    output addr_t maddr
  );
    miss = 1'b0;
    maddr = '0;
    if (taken) begin
      if (jump) begin
        // Predicted taken and jumped, wrong only if the target differs
        miss = (taddr != addr);
        maddr = addr;
      end else if (branch) begin
        miss = 1'b1;
        maddr = npc;
      end
    end else if (jump) begin
      miss = 1'b1;
      maddr = addr;
    end
  endfunction

  always_comb begin
    resolve_slot(upd_taken0_i, upd_taddr0_i, upd_jump0_i, upd_branch0_i,
                 upd_addr0_i, upd_npc0_i, miss0_o, maddr0_o);
    resolve_slot(upd_taken1_i, upd_taddr1_i, upd_jump1_i, upd_branch1_i,
                 upd_addr1_i, upd_npc1_i, miss1_o, maddr1_o);
  end

endmodule

// File: src/btac_update.sv
`timescale 1ns/10ps

module btac_update
  import btac_pkg::*;
(
  input  addr_t      upd_pc0_i,
  input  addr_t      upd_pc1_i,
  input  addr_t      upd_addr0_i,
  input  addr_t      upd_addr1_i,
  input  sat_t       upd_tsat0_i,
  input  sat_t       upd_tsat1_i,
  input  logic       upd_jal0_i,
  input  logic       upd_jal1_i,
  input  logic       upd_branch0_i,
  input  logic       upd_branch1_i,
  input  logic       upd_jump0_i,
  input  logic       upd_jump1_i,
  output logic       wen_o,
  output btb_index_t waddr_o,
  output btb_entry_t wdata_o
);

  localparam int IW = $bits(btb_index_t);
  localparam int TW = $bits(btb_tag_t);

  sat_t sat0;
  sat_t sat1;
  sat_t win_tsat;

  function automatic sat_t sat_next(sat_t sat, logic jump);
    sat_t res;
    res = sat;
    if (jump && sat != 2'b11) begin
      res = sat + 2'd1;
    end else if (!jump && sat != 2'b00) begin
      res = sat - 2'd1;
    end
    return res;
  endfunction

  always_comb begin
    sat0 = sat_next(upd_tsat0_i, upd_jump0_i);
    sat1 = sat_next(upd_tsat1_i, upd_jump1_i);
  end

  // Only taken control transfers allocate or refresh an entry
  assign wen_o = ((upd_jal0_i | upd_branch0_i) & upd_jump0_i) |
                 ((upd_jal1_i | upd_branch1_i) & upd_jump1_i);

  // Slot 0 wins whenever it jumped
  assign waddr_o = upd_jump0_i ? upd_pc0_i[IW+1:2] : upd_pc1_i[IW+1:2];

  assign wdata_o = upd_jump0_i ? {upd_pc0_i[31 -: TW], upd_addr0_i, sat0}
                               : {upd_pc1_i[31 -: TW], upd_addr1_i, sat1};

  // Counter of the winning slot before training
  assign win_tsat = upd_jump0_i ? upd_tsat0_i : upd_tsat1_i;

  // The counter stored with a written entry never jumps between the two extremes
  always_comb begin
    if (wen_o) begin
      a_no_wrap: assert (!(win_tsat == 2'b11 && wdata_o[1:0] == 2'b00) &&
                         !(win_tsat == 2'b00 && wdata_o[1:0] == 2'b11));
    end
  end

endmodule

// File: src/btb_ram.sv
`timescale 1ns/10ps
`include "btac_defines.svh"

module btb_ram
  import btac_pkg::*;
(
  input  logic       clock,
  input  btb_index_t raddr0_i,
  input  btb_index_t raddr1_i,
  input  btb_index_t waddr_i,
  input  logic       wen_i,
  input  btb_entry_t wdata_i,
  output btb_entry_t rdata0_o,
  output btb_entry_t rdata1_o
);

  // Empty entries read as zero, so every lookup misses until trained
  btb_entry_t mem [0:`BTAC_DEPTH-1] = '{default: '0};

  btb_index_t raddr0_q = '0;
  btb_index_t raddr1_q = '0;

  always_ff @(posedge clock) begin
    raddr0_q <= raddr0_i;
    raddr1_q <= raddr1_i;
    if (wen_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // Read data follows the index registered at the previous edge
  assign rdata0_o = mem[raddr0_q];
  assign rdata1_o = mem[raddr1_q];

  // A write must always land on a known entry
  a_waddr_known: assert property (
    @(posedge clock) wen_i |-> !$isunknown(waddr_i)
  );

endmodule

// File: testbench/btac_patterns.txt
# Inputs: get_pc0 get_pc1 clear stall, then for slot 0 and slot 1 each
#   upd pc npc addr jal branch jump taken taddr tsat
# Expected: taken0 taddr0 tsat0 taken1 taddr1 tsat1 hazard0 hazard1 miss maddr (all hex)
test jump_miss
0 0 0 0  44 48 200 1 0 1 0 0 1  0 0 0 0 0 0 0 0 0  0 0 0 0 0 0  1 0 0 0
0 0 0 0  0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0  0 0 0 0 0 0  0 0 1 200
0 0 0 0  50 54 0 0 1 0 1 400 2  60 64 0 0 1 0 1 500 2  0 0 0 0 0 0  1 1 0 0
0 0 0 0  0 0 0 0 0 0 0 0 0  60 64 0 0 1 0 1 500 2  0 0 0 0 0 0  0 1 1 54
0 0 0 0  0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0  0 0 0 0 0 0  0 0 1 64
test jal_train_lookup
44 44 0 0  0 0 0 0 0 0 0 0 0  48 4c 240 1 0 1 0 0 1  0 0 0 0 0 0  0 1 0 0
44 48 0 0  0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0  1 200 2 1 200 2  0 0 1 240
0 0 0 0  0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0  1 200 2 1 240 2  0 0 0 0
test tag_mismatch
84 84 0 0  0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0  0 0 0 0 0 0  0 0 0 0
0 0 0 0  0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0  0 200 2 0 200 2  0 0 0 0
test counter_saturation
0 0 0 0  4c 50 600 0 1 1 0 0 3  0 0 0 0 0 0 0 0 0  0 0 0 0 0 0  1 0 0 0
4c 4c 0 0  0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0  0 0 0 0 0 0  0 0 1 600
0 0 0 0  4c 50 0 0 1 0 1 600 3  0 0 0 0 0 0 0 0 0  1 600 3 1 600 3  1 0 0 0
4c 0 0 0  4c 50 600 0 1 1 1 600 3  0 0 0 0 0 0 0 0 0  0 0 0 0 0 0  0 0 1 50
0 0 0 0  0 0 0 0 0 0 0 0 0  54 58 700 1 0 1 0 0 0  1 600 3 0 0 0  0 1 0 0
54 54 0 0  0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0  0 0 0 0 0 0  0 0 1 700
0 0 0 0  0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0  0 700 1 0 700 1  0 0 0 0
test stall_clear
44 44 0 0  0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0  0 0 0 0 0 0  0 0 0 0
0 0 0 1  0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0  0 0 0 0 0 0  0 0 0 0
48 48 1 0  58 5c 800 1 0 1 0 0 1  0 0 0 0 0 0 0 0 0  0 0 0 0 0 0  0 0 0 0
58 58 0 0  0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0  0 0 0 0 0 0  0 0 0 0
0 0 0 0  0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0  0 0 0 0 0 0  0 0 0 0
test dual_jump
0 0 0 0  50 54 900 1 0 1 0 0 1  58 5c a00 1 0 1 0 0 1  0 0 0 0 0 0  1 1 0 0
50 58 0 0  0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0  0 0 0 0 0 0  0 0 1 900
0 0 0 0  0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0  1 900 2 0 0 0  0 0 0 0

// File: testbench/btac_tb.sv
`timescale 1ns/10ps
`include "btac_defines.svh"

module btac_tb
  import btac_pkg::*;
();

  localparam string PATTERN_FILE = "testbench/btac_patterns.txt";
  localparam int NFIELDS = 32;
  localparam int PERIOD = 100;

  logic  clock = 1'b0;
  logic  reset;
  logic  clear_i, stall_i;
  addr_t get_pc0_i, get_pc1_i;
  addr_t upd_pc0_i, upd_pc1_i;
  addr_t upd_npc0_i, upd_npc1_i;
  addr_t upd_addr0_i, upd_addr1_i;
  logic  upd_jal0_i, upd_jal1_i;
  logic  upd_branch0_i, upd_branch1_i;
  logic  upd_jump0_i, upd_jump1_i;
  logic  upd_taken0_i, upd_taken1_i;
  addr_t upd_taddr0_i, upd_taddr1_i;
  sat_t  upd_tsat0_i, upd_tsat1_i;
  logic  pred_taken0_o, pred_taken1_o;
  addr_t pred_taddr0_o, pred_taddr1_o;
  sat_t  pred_tsat0_o, pred_tsat1_o;
  logic  pred_hazard0_o, pred_hazard1_o;
  logic  pred_miss_o;
  addr_t pred_maddr_o;

  // Fields of the current pattern line, inputs first and expected outputs after
  logic [31:0] v [0:NFIELDS-1];
  string lines [$];
  string group_name = "unlabelled";
  int    group_lines = 0;
  int    group_errors = 0;
  int    pass_count = 0;
  int    fail_count = 0;
  int    n_cycles = 0;

  always #(PERIOD / 2) clock = ~clock;

  btac dut0 (.*);

  function automatic string strip_newline(string s);
    string r;
    r = s;
    while (r.len() > 0 && (r.getc(r.len() - 1) == 8'h0a || r.getc(r.len() - 1) == 8'h0d)) begin
      r = r.substr(0, r.len() - 2);
    end
    return r;
  endfunction

  function automatic bit is_label(string s);
    return s.len() > 5 && s.substr(0, 4) == "test ";
  endfunction

  task automatic load_patterns(output bit ok);
    int    fd;
    int    count;
    string line;
    ok = 1'b0;
    count = 0;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open pattern file %s", PATTERN_FILE);
    end else begin
      while ($fgets(line, fd) > 0) begin
        line = strip_newline(line);
        if (line.len() == 0 || line.substr(0, 0) == "#") begin
          continue;
        end
        lines.push_back(line);
        if (!is_label(line)) begin
          count++;
        end
      end
      $fclose(fd);
      ok = (count > 0);
      if (!ok) begin
        $display("Pattern file %s holds no data lines", PATTERN_FILE);
      end
      n_cycles = count;
    end
  endtask

  task automatic parse_line(input string s, output bit ok);
    string       tok;
    byte         c;
    int          n;
    int          rc;
    logic [31:0] value;
    n = 0;
    tok = "";
    ok = 1'b1;
    for (int i = 0; i <= s.len(); i++) begin
      c = (i < s.len()) ? s.getc(i) : 8'h20;
      if (c == 8'h20 || c == 8'h09) begin
        if (tok.len() > 0) begin
          rc = $sscanf(tok, "%h", value);
          if (n < NFIELDS && rc == 1) begin
            v[n] = value;
          end else begin
            ok = 1'b0;
          end
          n++;
          tok = "";
        end
      end else begin
        tok = {tok, s.substr(i, i)};
      end
    end
    if (n != NFIELDS) begin
      ok = 1'b0;
    end
  endtask

  task automatic apply_line();
    get_pc0_i = v[0];
    get_pc1_i = v[1];
    clear_i = v[2][0];
    stall_i = v[3][0];
    upd_pc0_i = v[4];
    upd_npc0_i = v[5];
    upd_addr0_i = v[6];
    upd_jal0_i = v[7][0];
    upd_branch0_i = v[8][0];
    upd_jump0_i = v[9][0];
    upd_taken0_i = v[10][0];
    upd_taddr0_i = v[11];
    upd_tsat0_i = v[12][1:0];
    upd_pc1_i = v[13];
    upd_npc1_i = v[14];
    upd_addr1_i = v[15];
    upd_jal1_i = v[16][0];
    upd_branch1_i = v[17][0];
    upd_jump1_i = v[18][0];
    upd_taken1_i = v[19][0];
    upd_taddr1_i = v[20];
    upd_tsat1_i = v[21][1:0];
  endtask

  task automatic drive_idle();
    foreach (v[i]) begin
      v[i] = '0;
    end
    apply_line();
  endtask

  task automatic compare_addr(input string name, input addr_t expected, input addr_t actual);
    if (actual !== expected) begin
      $display("FAILED %s expected %h actual %h at %0t", name, expected, actual, $time);
      group_errors++;
    end
  endtask

  task automatic compare_sat(input string name, input sat_t expected, input sat_t actual);
    if (actual !== expected) begin
      $display("FAILED %s expected %h actual %h at %0t", name, expected, actual, $time);
      group_errors++;
    end
  endtask

  task automatic compare_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("FAILED %s expected %h actual %h at %0t", name, expected, actual, $time);
      group_errors++;
    end
  endtask

  task automatic verify_outputs();
    compare_flag("pred_taken0_o", v[22][0], pred_taken0_o);
    compare_addr("pred_taddr0_o", v[23], pred_taddr0_o);
    compare_sat("pred_tsat0_o", v[24][1:0], pred_tsat0_o);
    compare_flag("pred_taken1_o", v[25][0], pred_taken1_o);
    compare_addr("pred_taddr1_o", v[26], pred_taddr1_o);
    compare_sat("pred_tsat1_o", v[27][1:0], pred_tsat1_o);
    compare_flag("pred_hazard0_o", v[28][0], pred_hazard0_o);
    compare_flag("pred_hazard1_o", v[29][0], pred_hazard1_o);
    compare_flag("pred_miss_o", v[30][0], pred_miss_o);
    // The redirect address only carries meaning together with a miss
    if (v[30][0]) begin
      compare_addr("pred_maddr_o", v[31], pred_maddr_o);
    end
  endtask

  task automatic end_group();
    if (group_lines > 0) begin
      if (group_errors == 0) begin
        $display("test %s: %0d cycles ok", group_name, group_lines);
        pass_count++;
      end else begin
        $display("test %s: %0d errors", group_name, group_errors);
        fail_count++;
      end
    end
    group_name = "unlabelled";
    group_lines = 0;
    group_errors = 0;
  endtask

  initial begin : main
    bit    ok;
    bit    line_ok;
    string cur;
    drive_idle();
    reset = 1'b0;
    load_patterns(ok);
    if (`BTAC_INDEX_BITS != 4) begin
      $display("Pattern addresses assume 4 index bits, found %0d", `BTAC_INDEX_BITS);
      ok = 1'b0;
    end
    if (ok) begin
      repeat (2) @(posedge clock);
      @(negedge clock);
      reset = 1'b1;
      foreach (lines[i]) begin
        cur = lines[i];
        if (is_label(cur)) begin
          end_group();
          group_name = cur.substr(5, cur.len() - 1);
        end else begin
          parse_line(cur, line_ok);
          group_lines++;
          if (line_ok) begin
            @(negedge clock);
            apply_line();
            // Sample shortly before the rising edge, when all outputs have settled
            #(PERIOD / 2 - 10);
            verify_outputs();
          end else begin
            $display("Pattern line could not be read: %s", cur);
            group_errors++;
          end
        end
      end
      end_group();
    end
    $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (ok && fail_count == 0 && pass_count > 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    wait (n_cycles > 0);
    #((n_cycles + 10) * PERIOD);
    $display("Timeout, the patterns did not finish within %0d cycles", n_cycles + 10);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule
